/* design/div_pkg.sv */
`default_nettype none

package div_pkg;

    // operand width of the integer datapath
    localparam int xlen = 32;

    // radix-16 digits, one per step
    localparam int digit_bits = 4;
    localparam int num_steps = xlen / digit_bits;

    // divisor times 1 through 15
    localparam int num_multiples = 2**digit_bits - 1;

    // registered steps are those with index % stage_period == stage_mod,
    // which with these values gives steps 0, 3 and 6
    localparam int stage_period = 3;
    localparam int stage_mod = 0;

    // cycles from the accepted cycle to the done cycle
    localparam int core_latency = 3;

    // matches funct3[1:0] of the M-extension divide group
    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_divu = 2'd1,
        op_rem  = 2'd2,
        op_remu = 2'd3
    } div_op_t;

    // travels with each division through the core
    typedef struct packed {
        // return the remainder instead of the quotient
        logic rem_sel;
        // two's complement the selected result
        logic negate;
    } div_tag_t;

    // partial results handed from one digit step to the next
    typedef struct packed {
        logic [xlen-1:0]   quo;
        // current remainder in the upper half, unused dividend bits below
        logic [2*xlen-1:0] rem;
    } div_state_t;

    // one divisor multiple, wide enough for 15 * divisor
    typedef logic [xlen+digit_bits-1:0] multiple_t;

endpackage

`default_nettype wire

/* design/div_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module div_stage import div_pkg::*; #(
    parameter bit is_registered = 1'b0
) (
    input  wire             clk,
    input  wire             rst_n,

    input  wire div_state_t state_in,
    input  wire multiple_t  mult_in [num_multiples],
    input  wire div_tag_t   tag_in,
    input  wire             flag_in,

    output div_state_t      state_out,
    output multiple_t       mult_out [num_multiples],
    output div_tag_t        tag_out,
    output logic            flag_out
);

    // current remainder with the next four dividend bits appended
    multiple_t             window;
    multiple_t             sel_mult;
    multiple_t             diff;
    logic [digit_bits-1:0] digit;
    div_state_t            next_state;

    assign window = state_in.rem[2*xlen-1 -: xlen+digit_bits];

    // walk up the multiples, the last one that fits wins
    always_comb begin
        digit = '0;
        sel_mult = '0;
        for (int k = 1; k <= num_multiples; k++) begin
            if (window >= mult_in[k-1]) begin
                digit = digit_bits'(k);
                sel_mult = mult_in[k-1];
            end
        end
    end

    assign diff = window - sel_mult;

    // new digit enters the quotient from the right and
    // the leftover goes back to the top of the remainder
    assign next_state = '{
        quo: {state_in.quo[xlen-digit_bits-1:0], digit},
        rem: {diff[xlen-1:0], state_in.rem[xlen-digit_bits-1:0], {digit_bits{1'b0}}}
    };

    generate
        if (is_registered) begin : g_reg
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    flag_out <= 1'b0;
                end else begin
                    flag_out <= flag_in;
                end
            end

            always_ff @(posedge clk) begin
                state_out <= next_state;
                mult_out  <= mult_in;
                tag_out   <= tag_in;
            end
        end else begin : g_comb
            assign state_out = next_state;
            assign mult_out  = mult_in;
            assign tag_out   = tag_in;
            assign flag_out  = flag_in;
        end
    endgenerate

    // the leftover must be smaller than the divisor again, so the
    // top digit of the difference is always clear
    a_digit_fits: assert property (
        @(posedge clk) disable iff (!rst_n)
        (is_registered && flag_in) |->
            (diff[xlen +: digit_bits] == '0) &&
            ((mult_in[0] == '0) || (diff < mult_in[0]))
    );

endmodule

`default_nettype wire

/* design/divu_remu.sv */
`timescale 1ns/10ps
`default_nettype none

module divu_remu import div_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,

    input  wire             order,
    output logic            accepted,
    output logic            done,

    input  wire [xlen-1:0]  dividend,
    input  wire [xlen-1:0]  divisor,
    input  wire div_tag_t   tag_in,

    output logic [xlen-1:0] quo,
    output logic [xlen-1:0] rem,
    output div_tag_t        tag_out
);

    logic busy;

    // entry s feeds step s and entry s+1 is what step s hands on
    div_state_t state_chain [num_steps+1];
    multiple_t  mult_chain  [num_steps+1][num_multiples];
    div_tag_t   tag_chain   [num_steps+1];
    logic       flag_chain  [num_steps+1];

    // one division in flight
    assign accepted = order & ~busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accepted) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // flag reaching the end means the last step is working this cycle
    assign done = flag_chain[num_steps];

    // divisor multiples enter at the first step and travel down the chain
    generate
        for (genvar k = 1; k <= num_multiples; k++) begin : g_mult
            assign mult_chain[0][k-1] = multiple_t'(divisor) * multiple_t'(k);
        end
    endgenerate

    assign state_chain[0] = '{
        quo: '0,
        rem: {{xlen{1'b0}}, dividend}
    };
    assign tag_chain[0]  = tag_in;
    assign flag_chain[0] = accepted;

    generate
        for (genvar s = 0; s < num_steps; s++) begin : g_step
            div_stage #(
                .is_registered ((s % stage_period) == stage_mod)
            ) u_stage (
                .clk       (clk),
                .rst_n     (rst_n),
                .state_in  (state_chain[s]),
                .mult_in   (mult_chain[s]),
                .tag_in    (tag_chain[s]),
                .flag_in   (flag_chain[s]),
                .state_out (state_chain[s+1]),
                .mult_out  (mult_chain[s+1]),
                .tag_out   (tag_chain[s+1]),
                .flag_out  (flag_chain[s+1])
            );
        end
    endgenerate

    // remainder ends up in the upper half after the last shift
    assign quo     = state_chain[num_steps].quo;
    assign rem     = state_chain[num_steps].rem[2*xlen-1 -: xlen];
    assign tag_out = tag_chain[num_steps];

    // no second order is taken while one is still in flight
    a_single_flight: assert property (
        @(posedge clk) disable iff (!rst_n)
        accepted |=> !accepted [*core_latency]
    );

    // fixed latency through the three stage registers
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        accepted |-> ##core_latency done
    );

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

endmodule

`default_nettype wire

/* design/div_sign_adjust.sv */
`timescale 1ns/10ps
`default_nettype none

module div_sign_adjust import div_pkg::*; (
    // operands on their way into the core
    input  wire div_op_t    op,
    input  wire [xlen-1:0]  rs1,
    input  wire [xlen-1:0]  rs2,
    output logic [xlen-1:0] a_mag,
    output logic [xlen-1:0] b_mag,
    output div_tag_t        tag,

    // results on their way out of the core
    input  wire [xlen-1:0]  quo,
    input  wire [xlen-1:0]  rem,
    input  wire div_tag_t   ret_tag,
    output logic [xlen-1:0] rd
);

    logic            is_signed;
    logic            a_neg;
    logic            b_neg;
    logic            b_zero;
    logic [xlen-1:0] sel_result;

    // div and rem are the even encodings
    assign is_signed = (op == op_div) || (op == op_rem);

    assign a_neg  = is_signed & rs1[xlen-1];
    assign b_neg  = is_signed & rs2[xlen-1];
    assign b_zero = (rs2 == '0);

    // most negative value maps onto 2**31, still fine as unsigned
    assign a_mag = a_neg ? -rs1 : rs1;
    assign b_mag = b_neg ? -rs2 : rs2;

    always_comb begin
        tag.rem_sel = (op == op_rem) || (op == op_remu);
        if (tag.rem_sel) begin
            // remainder follows the dividend sign
            tag.negate = a_neg;
        end else begin
            // divide by zero keeps the all ones quotient as is
            tag.negate = (a_neg ^ b_neg) & ~b_zero;
        end
    end

    // result select and sign restore
    assign sel_result = ret_tag.rem_sel ? rem : quo;
    assign rd         = ret_tag.negate ? -sel_result : sel_result;

endmodule

`default_nettype wire

/* design/div_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module div_unit import div_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,

    input  wire             order,
    input  wire div_op_t    op,
    input  wire [xlen-1:0]  rs1,
    input  wire [xlen-1:0]  rs2,

    output logic            accepted,
    output logic            done,
    output logic [xlen-1:0] rd
);

    // magnitudes and tag into the core
    logic [xlen-1:0] a_mag;
    logic [xlen-1:0] b_mag;
    div_tag_t        fwd_tag;

    // unsigned results and the tag that came back with them
    logic [xlen-1:0] core_quo;
    logic [xlen-1:0] core_rem;
    div_tag_t        ret_tag;

    div_sign_adjust u_sign (
        .op      (op),
        .rs1     (rs1),
        .rs2     (rs2),
        .a_mag   (a_mag),
        .b_mag   (b_mag),
        .tag     (fwd_tag),
        .quo     (core_quo),
        .rem     (core_rem),
        .ret_tag (ret_tag),
        .rd      (rd)
    );

    divu_remu u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (order),
        .accepted (accepted),
        .done     (done),
        .dividend (a_mag),
        .divisor  (b_mag),
        .tag_in   (fwd_tag),
        .quo      (core_quo),
        .rem      (core_rem),
        .tag_out  (ret_tag)
    );

endmodule

`default_nettype wire

/* sim/div_unit_vectors.svh */
`ifndef div_unit_vectors_svh
`define div_unit_vectors_svh

// directed vectors, one per line
// columns: name, op, rs1, rs2, expected rd
task automatic load_vectors();
    // unsigned quotient and remainder
    add_vector("divu_basic",      op_divu, 32'd100,       32'd7,         32'd14);
    add_vector("remu_basic",      op_remu, 32'd100,       32'd7,         32'd2);
    add_vector("divu_by_16",      op_divu, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0FFF_FFFF);
    add_vector("remu_by_16",      op_remu, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0000_000F);
    add_vector("divu_by_one",     op_divu, 32'h1234_5678, 32'd1,         32'h1234_5678);
    add_vector("divu_small_big",  op_divu, 32'd5,         32'hFFFF_FFFF, 32'd0);
    add_vector("remu_small_big",  op_remu, 32'd5,         32'hFFFF_FFFF, 32'd5);
    add_vector("divu_equal",      op_divu, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 32'd1);
    add_vector("divu_ffff",       op_divu, 32'hFFFF_FFFF, 32'h0001_0001, 32'h0000_FFFF);
    add_vector("remu_ffff",       op_remu, 32'hFFFF_FFFF, 32'h0001_0001, 32'd0);
    add_vector("divu_shift",      op_divu, 32'h9ABC_DEF0, 32'h0000_0010, 32'h09AB_CDEF);
    add_vector("divu_near_max",   op_divu, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 32'd1);
    add_vector("remu_near_max",   op_remu, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 32'd1);
    add_vector("divu_msb",        op_divu, 32'h8000_0000, 32'hFFFF_FFFF, 32'd0);
    add_vector("remu_msb",        op_remu, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);

    // signed, every sign combination
    add_vector("div_pos_pos",     op_div,  32'd20,        32'd6,         32'd3);
    add_vector("rem_pos_pos",     op_rem,  32'd20,        32'd6,         32'd2);
    add_vector("div_neg_pos",     op_div,  32'hFFFF_FFEC, 32'd6,         32'hFFFF_FFFD);
    add_vector("rem_neg_pos",     op_rem,  32'hFFFF_FFEC, 32'd6,         32'hFFFF_FFFE);
    add_vector("div_pos_neg",     op_div,  32'd20,        32'hFFFF_FFFA, 32'hFFFF_FFFD);
    add_vector("rem_pos_neg",     op_rem,  32'd20,        32'hFFFF_FFFA, 32'd2);
    add_vector("div_neg_neg",     op_div,  32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'd3);
    add_vector("rem_neg_neg",     op_rem,  32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'hFFFF_FFFE);
    add_vector("div_minus1_by_2", op_div,  32'hFFFF_FFFF, 32'd2,         32'd0);
    add_vector("rem_minus1_by_2", op_rem,  32'hFFFF_FFFF, 32'd2,         32'hFFFF_FFFF);
    add_vector("div_min_by_2",    op_div,  32'h8000_0000, 32'd2,         32'hC000_0000);
    add_vector("div_max_by_min",  op_div,  32'h7FFF_FFFF, 32'h8000_0000, 32'd0);
    add_vector("rem_max_by_min",  op_rem,  32'h7FFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF);
    add_vector("div_zero_num",    op_div,  32'd0,         32'd5,         32'd0);

    // divide by zero
    add_vector("divu_by_zero",    op_divu, 32'h1234_5678, 32'd0,         32'hFFFF_FFFF);
    add_vector("remu_by_zero",    op_remu, 32'h1234_5678, 32'd0,         32'h1234_5678);
    add_vector("div_pos_by_zero", op_div,  32'h1234_5678, 32'd0,         32'hFFFF_FFFF);
    add_vector("div_neg_by_zero", op_div,  32'hFFFF_FFEC, 32'd0,         32'hFFFF_FFFF);
    add_vector("rem_neg_by_zero", op_rem,  32'hFFFF_FFEC, 32'd0,         32'hFFFF_FFEC);

    // most negative value over minus one
    add_vector("div_overflow",    op_div,  32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_vector("rem_overflow",    op_rem,  32'h8000_0000, 32'hFFFF_FFFF, 32'd0);
endtask

`endif

/* sim/div_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module div_unit_tb import div_pkg::*; ();

    localparam int clk_period = 10;
    localparam int reset_cycles = 16;
    localparam int num_random = 200;
    localparam int max_wait = 20;
    // x^32 + x^22 + x^2 + x + 1, right shifting form
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    typedef struct packed {
        div_op_t         op;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
        logic [xlen-1:0] exp_rd;
    } stim_t;

    logic            clk;
    logic            rst_n;
    logic            order;
    div_op_t         op;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic            accepted;
    logic            done;
    logic [xlen-1:0] rd;

    string       vec_name [$];
    stim_t       vec_stim [$];
    logic [31:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_planned;

    div_unit dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (order),
        .op       (op),
        .rs1      (rs1),
        .rs2      (rs2),
        .accepted (accepted),
        .done     (done),
        .rd       (rd)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic add_vector(input string name, input div_op_t vop, input logic [xlen-1:0] a,
                              input logic [xlen-1:0] b, input logic [xlen-1:0] expected);
        vec_name.push_back(name);
        vec_stim.push_back('{op: vop, rs1: a, rs2: b, exp_rd: expected});
    endtask

    `include "div_unit_vectors.svh"

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [xlen-1:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[xlen-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // RISC-V M-extension divide rules
    function automatic logic [xlen-1:0] model_result(input div_op_t vop,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic [xlen-1:0]        quo;
        logic [xlen-1:0]        rem;
        sa = a;
        sb = b;
        if (b == '0) begin
            quo = '1;
            rem = a;
        end else if (vop == op_divu || vop == op_remu) begin
            quo = a / b;
            rem = a % b;
        end else if (a == {1'b1, {(xlen-1){1'b0}}} && b == '1) begin
            quo = a;
            rem = '0;
        end else begin
            // truncates toward zero
            quo = sa / sb;
            rem = sa % sb;
        end
        return (vop == op_rem || vop == op_remu) ? rem : quo;
    endfunction

    // outputs are looked at 1 ns after the falling edge
    task automatic next_sample();
        @(negedge clk);
        #1;
    endtask

    task automatic start_order(input stim_t s);
        @(negedge clk);
        order = 1'b1;
        op    = s.op;
        rs1   = s.rs1;
        rs2   = s.rs2;
        #1;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        while (!accepted && n < max_wait) begin
            next_sample();
            n++;
        end
    endtask

    // counts cycles after the accepted cycle until done
    task automatic wait_done(input logic drop, output int latency);
        latency = 0;
        do begin
            @(negedge clk);
            if (drop) begin
                order = 1'b0;
            end
            #1;
            latency++;
        end while (!done && latency < max_wait);
    endtask

    task automatic check_result(input string name, input stim_t s, input int latency,
                                inout logic failed);
        if (!done) begin
            $display("%s: no done within %0d cycles of the accepted order", name, max_wait);
            failed = 1'b1;
        end else begin
            if (latency != core_latency) begin
                $display("Mismatch %s latency: expected %0d, actual %0d",
                         name, core_latency, latency);
                failed = 1'b1;
            end
            if (rd !== s.exp_rd) begin
                $display("Mismatch %s: expected %h, actual %h", name, s.exp_rd, rd);
                failed = 1'b1;
            end
        end
    endtask

    task automatic finish_test(input string name, input logic failed);
        tests_run++;
        if (failed) begin
            errors++;
        end else begin
            $display("ok   %s", name);
        end
    endtask

    task automatic run_division(input string name, input stim_t s);
        int   latency;
        logic failed;
        failed = 1'b0;
        start_order(s);
        wait_accept();
        if (!accepted) begin
            $display("%s: the order was never accepted", name);
            failed = 1'b1;
            @(negedge clk);
            order = 1'b0;
        end else begin
            wait_done(1'b1, latency);
            check_result(name, s, latency, failed);
        end
        finish_test(name, failed);
    endtask

    // nothing may come out of the unit before the first order
    task automatic idle_check();
        logic failed;
        failed = 1'b0;
        repeat (8) begin
            next_sample();
            if (done || accepted) begin
                failed = 1'b1;
            end
        end
        if (failed) begin
            $display("done or accepted went high after reset with no order");
        end
        finish_test("idle_after_reset", failed);
    endtask

    // order stays high across done, second accept comes one cycle later
    task automatic held_order_check();
        stim_t s;
        int    latency;
        logic  failed;
        failed = 1'b0;
        s.op = op_rem;
        s.rs1 = 32'hFFFF_FF9C;
        s.rs2 = 32'd7;
        s.exp_rd = model_result(s.op, s.rs1, s.rs2);
        start_order(s);
        wait_accept();
        wait_done(1'b0, latency);
        check_result("held_first", s, latency, failed);
        if (accepted) begin
            $display("held_order: the order was accepted in the done cycle");
            failed = 1'b1;
        end
        next_sample();
        if (!accepted) begin
            $display("held_order: the held order was not accepted after done");
            failed = 1'b1;
        end
        wait_done(1'b1, latency);
        check_result("held_second", s, latency, failed);
        finish_test("held_order", failed);
    endtask

    initial begin : watchdog
        wait (tests_planned > 0);
        #((reset_cycles + tests_planned * (core_latency + 4) + 20) * clk_period);
        $display("watchdog: the run did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        stim_t           s;
        logic [xlen-1:0] pick;
        logic [xlen-1:0] shape;
        clk = 1'b0;
        rst_n = 1'b0;
        order = 1'b0;
        op = op_divu;
        rs1 = '0;
        rs2 = '0;
        errors = 0;
        tests_run = 0;
        tests_planned = 0;
        lfsr_state = 32'd94;
        load_vectors();
        tests_planned = vec_stim.size() + num_random + 2;

        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        idle_check();
        foreach (vec_stim[i]) begin
            run_division(vec_name[i], vec_stim[i]);
        end
        held_order_check();

        for (int i = 0; i < num_random; i++) begin
            draw_bits(2, pick);
            draw_bits(xlen, s.rs1);
            draw_bits(xlen, s.rs2);
            draw_bits(2, shape);
            s.op = div_op_t'(pick[1:0]);
            // small divisors fill the upper quotient digits, zero now and then
            case (shape[1:0])
                2'd1: s.rs2 = s.rs2 >> 20;
                2'd2: s.rs2 = s.rs2 >> 29;
                2'd3: s.rs1 = 32'h8000_0000;
                default: s.rs2 = s.rs2;
            endcase
            s.exp_rd = model_result(s.op, s.rs1, s.rs2);
            run_division($sformatf("random_%0d", i), s);
        end

        $display("tests run: %0d, failed: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+sim
design/div_pkg.sv
design/div_stage.sv
design/divu_remu.sv
design/div_sign_adjust.sv
design/div_unit.sv
sim/div_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = div_unit_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the testbench prints the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

# sources are not tracked one by one, rebuild every time
.PHONY: $(OBJ_DIR)/V$(TOP)
